//--- verilog/calc_pkg.sv
package calc_pkg;

  typedef logic [9:0] value_t;   // unsigned magnitude
  typedef logic [3:0] bcd_t;     // one decimal digit
  typedef logic [6:0] seg_t;     // active low, bit 0 is segment a

  localparam value_t max_value = 10'd999;

  ////////////////////
  // scan codes, set 2
  localparam logic [7:0] code_break  = 8'hF0;
  localparam logic [7:0] code_extend = 8'hE0;
  localparam logic [7:0] code_add    = 8'h1C;  // A
  localparam logic [7:0] code_sub    = 8'h1B;  // S
  localparam logic [7:0] code_mul    = 8'h22;  // X
  localparam logic [7:0] code_clear  = 8'h21;  // C
  localparam logic [7:0] code_enter  = 8'h5A;

  // [0] top row, [1] keypad; entries listed 9 down to 0
  localparam logic [1:0][9:0][7:0] digit_codes = {
    {8'h7D, 8'h75, 8'h6C, 8'h74, 8'h73, 8'h6B, 8'h7A, 8'h72, 8'h69, 8'h70},
    {8'h46, 8'h3E, 8'h3D, 8'h36, 8'h2E, 8'h25, 8'h26, 8'h1E, 8'h16, 8'h45}
  };

  typedef enum logic [2:0] {key_digit, key_add, key_sub, key_mul, key_clear, key_enter} key_kind_t;
  typedef enum logic [1:0] {op_none, op_add, op_sub, op_mul} op_t;
  typedef enum logic [1:0] {cmd_append, cmd_latch, cmd_compute, cmd_clear} cmd_kind_t;

  typedef struct packed {
    key_kind_t kind;
    bcd_t      digit;
  } key_event_t;

  typedef struct packed {
    cmd_kind_t kind;
    op_t       op;
    bcd_t      digit;
  } calc_cmd_t;

  ////////////////////
  // segment patterns, 9 down to 0
  localparam seg_t [9:0] seg_digits = {
    7'b0010000, 7'b0000000, 7'b1111000, 7'b0000010, 7'b0010010,
    7'b0011001, 7'b0110000, 7'b0100100, 7'b1111001, 7'b1000000
  };
  localparam seg_t seg_minus = 7'b0111111;  // middle segment only
  localparam seg_t seg_blank = 7'b1111111;

endpackage

//--- verilog/ps2_rx.sv
`timescale 1ns/1ps

module ps2_rx #(
  parameter int debounce_cycles = 15
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  localparam int cnt_w = $clog2(debounce_cycles + 1);

  logic [1:0] line_in;
  logic [1:0] sync_a;
  logic [1:0] sync_b;
  wire  [1:0] line_db;          // [0] clock, [1] data
  logic       clk_db_q;
  logic       clk_fall;
  logic       clk_rise;
  logic [3:0] bit_cnt;
  logic [10:0] frame;           // stop, parity, data[7:0], start
  logic       frame_ok;

  assign line_in = {ps2_data, ps2_clk};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sync_a <= 2'b11;          // lines idle high
      sync_b <= 2'b11;
    end else begin
      sync_a <= line_in;
      sync_b <= sync_a;
    end
  end

  ////////////////////
  // debounce, one per line
  for (genvar i = 0; i < 2; i++) begin : g_debounce
    logic [cnt_w-1:0] cnt;
    logic             held;
    logic             db;
    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        cnt  <= '0;
        held <= 1'b1;
        db   <= 1'b1;
      end else if (sync_b[i] != held) begin
        held <= sync_b[i];      // restart the stable count
        cnt  <= '0;
      end else if (cnt == cnt_w'(debounce_cycles)) begin
        db <= held;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
    assign line_db[i] = db;
  end

  ////////////////////
  // frame assembly
  assign clk_fall = clk_db_q & ~line_db[0];
  assign clk_rise = ~clk_db_q & line_db[0];
  assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);  // start, stop, odd parity

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      clk_db_q <= 1'b1;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      clk_db_q <= line_db[0];
      rx_valid <= 1'b0;
      if (clk_fall && bit_cnt != 4'd11) begin
        bit_cnt <= bit_cnt + 1'b1;
      end else if (clk_rise && bit_cnt == 4'd11) begin
        bit_cnt  <= '0;
        rx_valid <= frame_ok;   // bad frames vanish here
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clk_fall && bit_cnt != 4'd11)
      frame <= {line_db[1], frame[10:1]};  // lsb first
    if (clk_rise && bit_cnt == 4'd11)
      rx_byte <= frame[8:1];
  end

endmodule

//--- verilog/key_decoder.sv
`timescale 1ns/1ps

module key_decoder (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [7:0]            rx_byte,
  input  logic                  rx_valid,
  output calc_pkg::key_event_t  key,
  output logic                  key_valid
);

  import calc_pkg::*;

  logic       break_seen;
  logic       extend_seen;
  logic       known;
  key_event_t ev;

  always_comb begin
    known    = 1'b1;
    ev.kind  = key_digit;
    ev.digit = '0;
    case (rx_byte)
      code_add:   ev.kind = key_add;
      code_sub:   ev.kind = key_sub;
      code_mul:   ev.kind = key_mul;
      code_clear: ev.kind = key_clear;
      code_enter: ev.kind = key_enter;
      default: begin
        known = 1'b0;
        for (int t = 0; t < 2; t++) begin    // top row and keypad
          for (int d = 0; d < 10; d++) begin
            if (rx_byte == digit_codes[t][d]) begin
              known    = 1'b1;
              ev.digit = bcd_t'(d);
            end
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      break_seen  <= 1'b0;
      extend_seen <= 1'b0;
      key_valid   <= 1'b0;
    end else begin
      key_valid <= 1'b0;
      if (rx_valid) begin
        if (rx_byte == code_break) begin
          break_seen <= 1'b1;
        end else if (rx_byte == code_extend) begin
          extend_seen <= 1'b1;
        end else begin
          break_seen  <= 1'b0;
          extend_seen <= 1'b0;
          key_valid   <= known & ~break_seen & ~extend_seen;  // plain make codes only
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid)
      key <= ev;
  end

endmodule

//--- verilog/calc_control.sv
`timescale 1ns/1ps

module calc_control (
  input  logic                 clk,
  input  logic                 rst,
  input  calc_pkg::key_event_t key,
  input  logic                 key_valid,
  output calc_pkg::calc_cmd_t  cmd,
  output logic                 cmd_valid,
  output logic                 minus_en
);

  import calc_pkg::*;

  op_t       op;         // latched operation
  op_t       op_sel;
  cmd_kind_t next_kind;

  always_comb begin
    op_sel    = op;
    next_kind = cmd_append;
    case (key.kind)
      key_add:   begin op_sel = op_add; next_kind = cmd_latch; end
      key_sub:   begin op_sel = op_sub; next_kind = cmd_latch; end
      key_mul:   begin op_sel = op_mul; next_kind = cmd_latch; end
      key_enter: next_kind = cmd_compute;
      key_clear: begin op_sel = op_none; next_kind = cmd_clear; end
      default:   next_kind = cmd_append;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      op        <= op_none;
      cmd_valid <= 1'b0;
      minus_en  <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (key_valid) begin
        op        <= op_sel;
        cmd_valid <= (key.kind != key_enter) || (op != op_none);  // lone enter does nothing
        minus_en  <= (next_kind == cmd_latch) || (next_kind == cmd_compute);  // hidden while typing
      end
    end
  end

  always_ff @(posedge clk) begin
    if (key_valid)
      cmd <= '{kind: next_kind, op: op_sel, digit: key.digit};
  end

endmodule

//--- verilog/calc_alu.sv
`timescale 1ns/1ps

module calc_alu (
  input  logic                clk,
  input  logic                rst,
  input  calc_pkg::calc_cmd_t cmd,
  input  logic                cmd_valid,
  output calc_pkg::value_t    shown,
  output logic                negative
);

  import calc_pkg::*;

  value_t             ans;
  value_t             temp;        // first operand
  logic [13:0]        entry;
  logic signed [11:0] operand;
  logic signed [11:0] sum;
  logic [11:0]        mag;
  logic [19:0]        product;
  value_t             result;
  logic               result_neg;

  function automatic value_t clamp(input logic [19:0] v);
    return (v > 20'(max_value)) ? max_value : value_t'(v);
  endfunction

  ////////////////////
  // arithmetic
  always_comb begin
    entry   = 14'(ans) * 14'd10 + 14'(cmd.digit);
    operand = negative ? -$signed(12'(temp)) : $signed(12'(temp));
    if (cmd.op == op_sub)
      sum = operand - $signed(12'(ans));
    else
      sum = operand + $signed(12'(ans));
    mag     = sum[11] ? 12'(-sum) : 12'(sum);
    product = 20'(temp) * 20'(ans);
    case (cmd.op)
      op_add, op_sub: begin
        result     = clamp(20'(mag));
        result_neg = sum[11];
      end
      op_mul: begin
        result     = clamp(product);
        result_neg = negative;     // sign carried over
      end
      default: begin
        result     = ans;
        result_neg = negative;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ans      <= '0;
      temp     <= '0;
      shown    <= '0;
      negative <= 1'b0;
    end else if (cmd_valid) begin
      case (cmd.kind)
        cmd_append: begin
          if (entry <= 14'(max_value)) begin  // extra digit ignored past 999
            ans   <= value_t'(entry);
            shown <= value_t'(entry);
          end
        end
        cmd_latch: begin
          temp <= ans;
          ans  <= '0;              // shown keeps the old number
        end
        cmd_compute: begin
          ans      <= result;
          shown    <= result;
          negative <= result_neg;
        end
        default: begin
          ans      <= '0;
          temp     <= '0;
          shown    <= '0;
          negative <= 1'b0;
        end
      endcase
    end
  end

endmodule

//--- verilog/seg_display.sv
`timescale 1ns/1ps

module seg_display #(
  parameter int scan_div_bits = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  calc_pkg::value_t shown,
  input  logic             negative,
  input  logic             minus_en,
  output logic [3:0]       digit,
  output calc_pkg::seg_t   display
);

  import calc_pkg::*;

  logic [scan_div_bits-1:0] prescale;
  logic                     scan_en;
  logic [1:0]               pos;       // 0 ones, 1 tens, 2 hundreds, 3 sign
  logic [1:0]               pos_next;
  bcd_t                     hundreds;
  bcd_t                     tens;
  bcd_t                     ones;

  function automatic seg_t seg_of(input bcd_t d);
    return (d <= 4'd9) ? seg_digits[d] : seg_blank;
  endfunction

  assign scan_en  = &prescale;
  assign pos_next = pos + 2'd1;

  ////////////////////
  // scan
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      prescale <= '0;
      pos      <= 2'd0;
      digit    <= 4'b1110;
    end else begin
      prescale <= prescale + 1'b1;
      if (scan_en) begin
        pos   <= pos_next;
        digit <= ~(4'b0001 << pos_next);  // one-cold select
      end
    end
  end

  // decimal split
  assign hundreds = bcd_t'(shown / 10'd100);
  assign tens     = bcd_t'((shown / 10'd10) % 10'd10);
  assign ones     = bcd_t'(shown % 10'd10);

  always_comb begin
    case (pos)
      2'd0: display = seg_of(ones);
      2'd1: begin
        if (hundreds == 4'd0 && tens == 4'd0)
          display = seg_blank;     // leading zero
        else
          display = seg_of(tens);
      end
      2'd2: display = (hundreds == 4'd0) ? seg_blank : seg_of(hundreds);
      default: display = (negative && minus_en) ? seg_minus : seg_blank;
    endcase
  end

endmodule

//--- verilog/calc_top.sv
`timescale 1ns/1ps

module calc_top #(
  parameter int debounce_cycles = 15,
  parameter int scan_div_bits   = 16
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           ps2_clk,
  input  logic           ps2_data,
  output logic [3:0]     digit,
  output calc_pkg::seg_t display
);

  import calc_pkg::*;

  logic [7:0] rx_byte;
  logic       rx_valid;
  key_event_t key;
  logic       key_valid;
  calc_cmd_t  cmd;
  logic       cmd_valid;
  logic       minus_en;
  value_t     shown;
  logic       negative;

  ps2_rx #(.debounce_cycles(debounce_cycles)) i_rx (
    .clk(clk), .rst(rst), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
    .rx_byte(rx_byte), .rx_valid(rx_valid)
  );

  key_decoder i_keys (
    .clk(clk), .rst(rst), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .key(key), .key_valid(key_valid)
  );

  calc_control i_ctrl (
    .clk(clk), .rst(rst), .key(key), .key_valid(key_valid),
    .cmd(cmd), .cmd_valid(cmd_valid), .minus_en(minus_en)
  );

  calc_alu i_alu (
    .clk(clk), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid),
    .shown(shown), .negative(negative)
  );

  seg_display #(.scan_div_bits(scan_div_bits)) i_seg (
    .clk(clk), .rst(rst), .shown(shown), .negative(negative), .minus_en(minus_en),
    .digit(digit), .display(display)
  );

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter real period_ns = 8.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2.0) clk = ~clk;  // free running, starts low
  end

endmodule

//--- verification/calc_checker.sv
`timescale 1ns/1ps

module calc_checker (
  input logic       clk,
  input logic       rst,
  input logic [3:0] digit,
  input logic [6:0] display,
  input logic       rx_valid,
  input logic       key_valid,
  input logic       cmd_valid
);

  int fail_cnt = 0;              // failed assertions so far

  ////////////////////
  // display outputs
  a_digit_one_cold: assert property (@(posedge clk) disable iff (rst) $countones(~digit) == 1)
    else begin
      $error("digit select is not one-cold: %b", digit);
      fail_cnt++;
    end

  a_display_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(display))
    else begin
      $error("segment outputs are unknown");
      fail_cnt++;
    end

  ////////////////////
  // strobes last one cycle
  a_rx_pulse: assert property (@(posedge clk) disable iff (rst) rx_valid |=> !rx_valid)
    else begin
      $error("rx_valid stayed high for two cycles");
      fail_cnt++;
    end

  a_key_pulse: assert property (@(posedge clk) disable iff (rst) key_valid |=> !key_valid)
    else begin
      $error("key_valid stayed high for two cycles");
      fail_cnt++;
    end

  a_cmd_pulse: assert property (@(posedge clk) disable iff (rst) cmd_valid |=> !cmd_valid)
    else begin
      $error("cmd_valid stayed high for two cycles");
      fail_cnt++;
    end

endmodule

//--- verification/tb_monitor.sv
`timescale 1ns/1ps

module tb_monitor (
  input  logic         clk,
  input  logic [3:0]   digit,
  input  logic [6:0]   display,
  input  logic         check_req,
  input  logic [255:0] test_name,
  input  logic [9:0]   exp_value,
  input  logic         exp_minus,
  output logic         check_done,
  output int           checks,
  output int           mismatches,
  output int           timeouts
);

  localparam int         scan_limit = 512;         // clocks, several scans at the test divider
  localparam logic [6:0] blank      = 7'b1111111;
  localparam logic [6:0] minus      = 7'b0111111;  // segment g only

  logic [6:0] seen [0:3];                          // ones, tens, hundreds, sign
  logic [6:0] want [0:3];

  // active low, bit 0 is segment a
  function automatic logic [6:0] seg_pattern(input int d);
    case (d)
      0: return 7'b1000000;
      1: return 7'b1111001;
      2: return 7'b0100100;
      3: return 7'b0110000;
      4: return 7'b0011001;
      5: return 7'b0010010;
      6: return 7'b0000010;
      7: return 7'b1111000;
      8: return 7'b0000000;
      9: return 7'b0010000;
      default: return blank;
    endcase
  endfunction

  ////////////////////
  // one full scan, sampled on the falling edge
  task automatic capture_scan(input string name);
    int         k;
    int         t;
    logic [3:0] sel;
    for (k = 0; k < 4; k++) begin
      sel = ~(4'b0001 << k);
      t = 0;
      @(negedge clk);
      while (digit !== sel && t < scan_limit) begin
        @(negedge clk);
        t++;
      end
      if (digit !== sel) begin
        $display("timeout in test %s: digit select %b never came up", name, sel);
        timeouts++;
      end
      seen[k] = display;
    end
  endtask

  task automatic compare_scan(input string name);
    int   hundreds;
    int   tens;
    int   ones;
    int   k;
    logic bad;
    hundreds = exp_value / 100;
    tens     = (exp_value / 10) % 10;
    ones     = exp_value % 10;
    want[0]  = seg_pattern(ones);
    want[1]  = (hundreds == 0 && tens == 0) ? blank : seg_pattern(tens);  // leading zeros off
    want[2]  = (hundreds == 0) ? blank : seg_pattern(hundreds);
    want[3]  = exp_minus ? minus : blank;
    bad = 1'b0;
    for (k = 0; k < 4; k++) begin
      if (seen[k] !== want[k])
        bad = 1'b1;
    end
    checks++;
    if (bad) begin
      mismatches++;
      $display("ERR %s expected %0d sign %0b (%b %b %b %b) actual (%b %b %b %b)",
               name, exp_value, exp_minus, want[3], want[2], want[1], want[0],
               seen[3], seen[2], seen[1], seen[0]);
    end
  endtask

  initial begin
    string name;
    check_done = 1'b0;
    checks     = 0;
    mismatches = 0;
    timeouts   = 0;
    forever begin
      @(negedge clk);
      if (check_req && !check_done) begin
        name = string'(test_name);
        capture_scan(name);
        compare_scan(name);
        check_done = 1'b1;
      end else if (!check_req) begin
        check_done = 1'b0;                         // ready for the next request
      end
    end
  end

endmodule

//--- verification/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  localparam string stim_path = "verification/calc_stim.txt";
  localparam int    ack_limit = 4000;     // clocks

  logic         clk;
  logic         rst;
  logic         ps2_clk;
  logic         ps2_data;
  logic [3:0]   digit;
  logic [6:0]   display;
  logic         check_req;
  logic         check_done;
  logic [255:0] test_name;
  logic [9:0]   exp_value;
  logic         exp_minus;
  int           checks;
  int           mismatches;
  int           scan_timeouts;
  int           ack_timeouts;
  int           stim_errors;
  string        toks[$];

  tb_clock #(.period_ns(8.0)) i_clock (.clk(clk));

  calc_top #(.debounce_cycles(3), .scan_div_bits(4)) i_dut (
    .clk(clk), .rst(rst), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
    .digit(digit), .display(display)
  );

  tb_monitor i_monitor (
    .clk(clk), .digit(digit), .display(display), .check_req(check_req),
    .test_name(test_name), .exp_value(exp_value), .exp_minus(exp_minus),
    .check_done(check_done), .checks(checks), .mismatches(mismatches),
    .timeouts(scan_timeouts)
  );

  bind calc_top calc_checker i_checker (
    .clk(clk), .rst(rst), .digit(digit), .display(display),
    .rx_valid(rx_valid), .key_valid(key_valid), .cmd_valid(cmd_valid)
  );

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
    #1;                                   // inputs move just after the edge
  endtask

  ////////////////////
  // device to host frame sent lsb first
  task automatic send_frame(input logic [7:0] b, input logic bad);
    logic [10:0] bits;
    logic        parity;
    int          i;
    parity = ~(^b);                       // odd over data and parity
    if (bad)
      parity = ~parity;
    bits = {1'b1, parity, b, 1'b0};
    for (i = 0; i < 11; i++) begin
      ps2_data = bits[i];
      wait_clocks(10);
      ps2_clk = 1'b0;                     // host samples on this edge
      wait_clocks(20);
      ps2_clk = 1'b1;
      wait_clocks(10);
    end
    ps2_data = 1'b1;
    wait_clocks(40);                      // idle gap
  endtask

  task automatic split_line(input string line);
    int  i;
    int  start;
    byte c;
    toks.delete();
    start = -1;
    for (i = 0; i < line.len(); i++) begin
      c = line.getc(i);
      if (c == 8'h20 || c == 8'h09 || c == 8'h0a || c == 8'h0d) begin
        if (start >= 0)
          toks.push_back(line.substr(start, i - 1));
        start = -1;
      end else if (start < 0) begin
        start = i;
      end
    end
    if (start >= 0)
      toks.push_back(line.substr(start, line.len() - 1));
  endtask

  // monitor handshake holds req until done comes back
  task automatic request_check();
    int t;
    check_req = 1'b1;
    t = 0;
    while (check_done !== 1'b1 && t < ack_limit) begin
      @(posedge clk);
      t++;
    end
    #1;
    check_req = 1'b0;
    if (check_done !== 1'b1) begin
      $display("display monitor never answered for test %s", string'(test_name));
      ack_timeouts++;
    end
    t = 0;
    while (check_done !== 1'b0 && t < ack_limit) begin
      @(posedge clk);
      t++;
    end
    #1;
    if (check_done !== 1'b0) begin
      $display("display monitor never dropped its done flag for test %s",
               string'(test_name));
      ack_timeouts++;
    end
  endtask

  initial begin
    int    fd;
    int    k;
    int    last;
    int    total;
    string line;
    string tok;
    logic  bad;
    rst          = 1'b1;
    ps2_clk      = 1'b1;                  // both lines idle high
    ps2_data     = 1'b1;
    check_req    = 1'b0;
    test_name    = '0;
    exp_value    = '0;
    exp_minus    = 1'b0;
    ack_timeouts = 0;
    stim_errors  = 0;
    wait_clocks(4);
    rst = 1'b0;
    wait_clocks(20);
    fd = $fopen(stim_path, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", stim_path);
      stim_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        split_line(line);
        if (toks.size() == 0)
          continue;
        tok = toks[0];
        if (tok.getc(0) == "#")
          continue;
        last = toks.size() - 1;
        if (last < 3 || toks[last - 2] != "=") begin
          $display("stimulus line not understood: %s", line);
          stim_errors++;
          continue;
        end
        $sformat(test_name, "%s", toks[0]);
        for (k = 1; k < last - 2; k++) begin
          tok = toks[k];
          bad = (tok.getc(0) == "!");
          if (bad)
            tok = tok.substr(1, tok.len() - 1);
          send_frame(8'(tok.atohex()), bad);
        end
        exp_value = 10'(toks[last - 1].atoi());
        exp_minus = (toks[last].atoi() != 0);
        wait_clocks(60);                  // pipeline settle
        request_check();
      end
      $fclose(fd);
    end
    total = mismatches + scan_timeouts + ack_timeouts + stim_errors
          + i_dut.i_checker.fail_cnt;
    $display("checks %0d, mismatches %0d, scan timeouts %0d, handshake timeouts %0d, %0s",
             checks, mismatches, scan_timeouts, ack_timeouts,
             $sformatf("stim errors %0d, assertion failures %0d",
                       stim_errors, i_dut.i_checker.fail_cnt));
    if (total == 0 && checks > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- verification/calc_stim.txt
# name  scan code bytes in hex, a leading ! sends that frame with bad parity
# then =, the expected shown value, and 1 when the minus sign is lit
reset_value = 0 0
top_row 16 1e 26 = 123 0
fourth_digit 25 = 123 0
keypad 21 70 70 73 = 5 0
keypad_more 74 6c = 567 0
add_latch 21 16 1e 26 1c = 123 0
add_operand 25 2e 36 = 456 0
add_result 5a = 579 0
add_clamp 21 2e 45 45 1c 36 45 45 5a = 999 0
mul_small 21 16 1e 22 16 1e 5a = 144 0
mul_clamp 21 25 2e 22 26 45 5a = 999 0
sub_negative 21 2e 1b 3e 5a = 3 1
digit_drops_minus 1e = 32 0
sub_again 21 1e 1b 2e 5a = 3 1
add_keeps_number 1c = 3 1
add_cross_zero 46 5a = 6 0
release 21 16 f0 16 f0 1e = 1 0
extended e0 70 e0 f0 70 = 1 0
bad_parity !1e = 1 0
after_bad_frame 1e = 12 0
enter_no_op 21 26 5a = 3 0
neg_then_clear 21 16 1b 3e 5a = 7 1
clear_sign 21 = 0 0

//--- verilog.f
verilog/calc_pkg.sv
verilog/ps2_rx.sv
verilog/key_decoder.sv
verilog/calc_control.sv
verilog/calc_alu.sv
verilog/seg_display.sv
verilog/calc_top.sv
verification/tb_clock.sv
verification/calc_checker.sv
verification/tb_monitor.sv
verification/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the calculator testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f verilog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_top +verilator+error+limit+1000 > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "STATUS: FAIL" "$log"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
if ! grep -q "STATUS: PASS" "$log"; then
  echo "no result line found in $log"
  exit 1
fi
exit 0
